/* apu.f */
src/apu_pkg.sv
src/apu_alu.sv
src/apu_regfile.sv
src/apu_exec.sv
src/apu_apb_slave.sv
src/apu_top.sv
testbench/apu_assert.sv
testbench/apu_tb.sv

/* run.sh */
#!/bin/sh
# Build the APU testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module apu_tb -f apu.f -o apu_sim \
	&& ./obj_dir/apu_sim > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qF '*** TEST PASSED ***' sim.log 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* testbench/apu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_tb;

	localparam int N_ROWS   = 37;
	localparam int CLK_HALF = 50;

	typedef struct packed {
		apu_pkg::data_t      a;      // Preload for r1
		apu_pkg::data_t      b;      // Preload for r2
		apu_pkg::apu_cmd_t   cmd;
		apu_pkg::data_t      result;
		apu_pkg::apu_flags_t flags;
	} row_t;

	logic               clk;
	logic               rst;
	logic               psel;
	logic               penable;
	logic               pwrite;
	apu_pkg::apb_addr_t paddr;
	apu_pkg::data_t     pwdata;
	apu_pkg::data_t     prdata;
	logic               pready;

	row_t rows [N_ROWS];
	int   n_rows;
	int   n_checks;
	int   n_mismatch;
	int   n_error;
	int   last_waits;   // Wait states of the latest write
	logic reported;

	apu_top i_apu_top (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	function automatic apu_pkg::apb_addr_t reg_addr(input int n);
		return apu_pkg::ADDR_REG0 + apu_pkg::apb_addr_t'(4 * n);
	endfunction

	task automatic check_value(input string what, input apu_pkg::data_t got,
			input apu_pkg::data_t want);
		n_checks++;
		if (got !== want) begin
			n_mismatch++;
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic bus_write(input apu_pkg::apb_addr_t addr, input apu_pkg::data_t data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		last_waits = 0;
		@(posedge clk);
		while (!pready) begin   // Slave holds writes while a command runs
			last_waits++;
			@(posedge clk);
		end
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic bus_read(input apu_pkg::apb_addr_t addr, output apu_pkg::data_t data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready)
			@(posedge clk);
		data = prdata;
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_idle(output apu_pkg::data_t st);
		int polls;
		polls = 0;
		bus_read(apu_pkg::ADDR_STATUS, st);
		while (st[apu_pkg::STATUS_BUSY] && polls < 20) begin
			polls++;
			bus_read(apu_pkg::ADDR_STATUS, st);
		end
		if (st[apu_pkg::STATUS_BUSY]) begin
			n_error++;
			$display("Sequencer still busy after %0d STATUS polls", polls);
		end
	endtask

	task automatic add_row(input apu_pkg::alu_func_t func, input apu_pkg::alu_size_t sz,
			input apu_pkg::data_t a, b, result, input logic [3:0] flags);
		row_t r;
		r.a        = a;
		r.b        = b;
		r.cmd.func = func;
		r.cmd.sz   = sz;
		r.cmd.dst  = apu_pkg::reg_addr_t'(3 + n_rows % 5); // Spread over r3 to r7
		r.cmd.src  = 3'd1;
		r.cmd.arg  = 3'd2;
		r.result   = result;
		r.flags    = flags;
		rows[n_rows] = r;
		n_rows++;
	endtask

	// Flag order is z s c v
	// ADC SBC RRC RLC take C from the row before
	task automatic fill_table();
		add_row(apu_pkg::FN_LOAD, 2'd0, 32'h1234_5600, 32'h0, 32'h1234_5600, 4'b1000);
		add_row(apu_pkg::FN_AND,  2'd3, 32'hf0f0_1234, 32'hff00_ff00, 32'hf000_1200, 4'b0100);
		add_row(apu_pkg::FN_OR,   2'd1, 32'h0000_8001, 32'h1234_0000, 32'h1234_8001, 4'b0100);
		add_row(apu_pkg::FN_XOR,  2'd2, 32'hab12_3456, 32'hcd12_3456, 32'h6600_0000, 4'b1000);
		add_row(apu_pkg::FN_ADD,  2'd0, 32'h0000_01f0, 32'h0000_0020, 32'h0000_0010, 4'b0010);
		add_row(apu_pkg::FN_ADC,  2'd0, 32'h0000_0010, 32'h0000_000f, 32'h0000_0020, 4'b0000);
		add_row(apu_pkg::FN_SUB,  2'd0, 32'h0000_0005, 32'h0000_0006, 32'h0000_00ff, 4'b0110);
		add_row(apu_pkg::FN_SBC,  2'd0, 32'h0000_0010, 32'h0000_000f, 32'h0000_0000, 4'b1000);
		add_row(apu_pkg::FN_ADD,  2'd1, 32'hffff_8000, 32'h0000_8000, 32'h0000_0000, 4'b1010);
		add_row(apu_pkg::FN_ADC,  2'd1, 32'h0000_1234, 32'h0000_0001, 32'h0000_1236, 4'b0000);
		add_row(apu_pkg::FN_SUB,  2'd1, 32'h0000_0100, 32'h0000_0200, 32'h0000_ff00, 4'b0110);
		add_row(apu_pkg::FN_SBC,  2'd1, 32'h0000_8000, 32'h0000_0000, 32'h0000_7fff, 4'b0000);
		add_row(apu_pkg::FN_ADD,  2'd2, 32'h00ff_ffff, 32'h0000_0001, 32'h0000_0000, 4'b1010);
		add_row(apu_pkg::FN_ADC,  2'd2, 32'h0040_0000, 32'h0040_0000, 32'h0080_0001, 4'b0100);
		add_row(apu_pkg::FN_SUB,  2'd2, 32'h0000_0000, 32'h0000_0001, 32'h00ff_ffff, 4'b0110);
		add_row(apu_pkg::FN_SBC,  2'd2, 32'h0000_0003, 32'h0000_0001, 32'h0000_0001, 4'b0000);
		add_row(apu_pkg::FN_ADD,  2'd3, 32'hffff_ffff, 32'h0000_0002, 32'h0000_0001, 4'b0010);
		add_row(apu_pkg::FN_ADC,  2'd3, 32'h7fff_ffff, 32'h0000_0000, 32'h8000_0000, 4'b0100);
		add_row(apu_pkg::FN_SBC,  2'd3, 32'h0000_0001, 32'h0000_0000, 32'h0000_0001, 4'b0000);
		add_row(apu_pkg::FN_SUB,  2'd3, 32'h0000_0010, 32'h0000_0020, 32'hffff_fff0, 4'b0110);
		add_row(apu_pkg::FN_RR,   2'd0, 32'hffff_ff81, 32'h0, 32'h0000_00c0, 4'b0110);
		add_row(apu_pkg::FN_RRC,  2'd0, 32'h0000_0002, 32'h0, 32'h0000_0081, 4'b0100);
		add_row(apu_pkg::FN_SRA,  2'd0, 32'h0000_0084, 32'h0, 32'h0000_00c2, 4'b0100);
		add_row(apu_pkg::FN_SRZ,  2'd0, 32'h0000_0001, 32'h0, 32'h0000_0000, 4'b1010);
		add_row(apu_pkg::FN_RL,   2'd0, 32'h0000_0081, 32'h0, 32'h0000_0003, 4'b0010);
		add_row(apu_pkg::FN_RLC,  2'd0, 32'h0000_0040, 32'h0, 32'h0000_0081, 4'b0100);
		add_row(apu_pkg::FN_RR,   2'd3, 32'h0000_0003, 32'h0, 32'h8000_0001, 4'b0110);
		add_row(apu_pkg::FN_RRC,  2'd3, 32'h8000_0000, 32'h0, 32'hc000_0000, 4'b0100);
		add_row(apu_pkg::FN_SRA,  2'd3, 32'h8000_0002, 32'h0, 32'hc000_0001, 4'b0100);
		add_row(apu_pkg::FN_SRZ,  2'd3, 32'h8000_0001, 32'h0, 32'h4000_0000, 4'b0010);
		add_row(apu_pkg::FN_RLC,  2'd3, 32'h0000_0000, 32'h0, 32'h0000_0001, 4'b0000);
		add_row(apu_pkg::FN_RL,   2'd3, 32'h8000_0001, 32'h0, 32'h0000_0003, 4'b0010);
		add_row(apu_pkg::FN_MUL,  2'd0, 32'h0000_0f10, 32'h0000_0011, 32'h0000_0010, 4'b0000);
		add_row(apu_pkg::FN_MULS, 2'd1, 32'hffff_ffff, 32'h0000_00ff, 32'h0000_fe01, 4'b0100);
		add_row(apu_pkg::FN_MUL,  2'd2, 32'h0000_ffff, 32'h0000_ffff, 32'h00fe_0001, 4'b0100);
		add_row(apu_pkg::FN_MULS, 2'd3, 32'habcd_ffff, 32'h1234_ffff, 32'hfffe_0001, 4'b0100);
		add_row(apu_pkg::FN_MUL,  2'd3, 32'h0001_0000, 32'h0000_0005, 32'h0000_0000, 4'b1000);
	endtask

	task automatic check_registers();
		apu_pkg::data_t vals [8];
		apu_pkg::data_t got;
		for (int i = 0; i < 8; i++) begin
			vals[i] = $urandom;
			bus_write(reg_addr(i), vals[i]);
		end
		for (int i = 0; i < 8; i++) begin
			bus_read(reg_addr(i), got);
			check_value($sformatf("r%0d readback", i), got, vals[i]);
		end
		bus_write(8'h30, $urandom);   // Word offset aliases r4 if decoded as a register
		bus_read(8'h30, got);
		check_value("unmapped 0x30", got, 32'h0);
		bus_read(8'hfc, got);
		check_value("unmapped 0xfc", got, 32'h0);
		bus_read(reg_addr(4), got);
		check_value("r4 after unmapped write", got, vals[4]);
	endtask

	task automatic run_row(input int n);
		row_t           r;
		apu_pkg::data_t got;
		r = rows[n];
		bus_write(reg_addr(1), r.a);
		bus_write(reg_addr(2), r.b);
		bus_write(apu_pkg::ADDR_CMD, {17'd0, r.cmd});
		wait_idle(got);
		bus_read(reg_addr(int'(r.cmd.dst)), got);
		check_value($sformatf("row %0d result", n), got, r.result);
		bus_read(apu_pkg::ADDR_STATUS, got);
		check_value($sformatf("row %0d status", n), got, {28'd0, r.flags});
	endtask

	// Overwrite the source register while the LOAD is still running
	task automatic check_stall();
		apu_pkg::apu_cmd_t cmd;
		apu_pkg::data_t    got;
		cmd.func = apu_pkg::FN_LOAD;
		cmd.sz   = 2'd3;
		cmd.dst  = 3'd5;
		cmd.src  = 3'd1;
		cmd.arg  = 3'd2;
		bus_write(reg_addr(1), 32'h1111_1111);
		bus_write(apu_pkg::ADDR_CMD, {17'd0, cmd});
		bus_write(reg_addr(1), 32'h2222_2222);
		if (last_waits < 1) begin
			n_error++;
			$display("Register write during a running command was not stalled");
		end
		bus_read(apu_pkg::ADDR_STATUS, got);
		check_value("status after stalled write", got, 32'h0);
		bus_read(reg_addr(5), got);
		check_value("r5 loaded before stalled write", got, 32'h1111_1111);
		bus_read(reg_addr(1), got);
		check_value("r1 after stalled write", got, 32'h2222_2222);
	endtask

	initial begin
		rst        = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		n_rows     = 0;
		n_checks   = 0;
		n_mismatch = 0;
		n_error    = 0;
		last_waits = 0;
		reported   = 1'b0;
		void'($urandom(32'hec5));
		fill_table();
		if (n_rows != N_ROWS) begin
			n_error++;
			$display("Test table holds %0d rows instead of %0d", n_rows, N_ROWS);
		end
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		check_registers();
		for (int n = 0; n < n_rows; n++)
			run_row(n);
		check_stall();
		@(posedge clk);
		$display("Checks %0d, mismatches %0d, other errors %0d",
			n_checks, n_mismatch, n_error);
		reported = 1'b1;
		if (n_mismatch == 0 && n_error == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		repeat (N_ROWS * 40 + 500) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish",
			N_ROWS * 40 + 500);
		reported = 1'b1;
		$display("*** TEST FAILED ***");
		$finish;
	end

	// Run stopped by a failed assertion
	final begin
		if (!reported)
			$display("*** TEST FAILED ***");
	end

endmodule

`default_nettype wire

/* testbench/apu_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_assert (
	input wire                     clk,
	input wire                     rst,
	input wire                     psel,
	input wire                     penable,
	input wire                     pwrite,
	input wire apu_pkg::apb_addr_t paddr,
	input wire                     pready,
	input wire                     busy,
	input wire                     cmd_valid
);

	logic cmd_xfer;

	assign cmd_xfer = psel && penable && pready && pwrite && paddr == apu_pkg::ADDR_CMD;

	// cmd_valid, then EX_READ and EX_WRITE, then idle again
	a_cmd_timing: assert property (@(posedge clk) disable iff (rst)
		cmd_xfer |=> cmd_valid ##1 busy ##1 busy ##1 !busy)
		else $error("CMD transfer not followed by exactly two busy cycles");

	a_write_stall: assert property (@(posedge clk) disable iff (rst)
		(psel && penable && pwrite && busy) |-> !pready)
		else $error("Write completed while the sequencer was busy");

	// busy is high exactly when the FSM is outside EX_IDLE
	a_idle_hold: assert property (@(posedge clk) disable iff (rst)
		(!busy && !cmd_valid) |=> !busy)
		else $error("Sequencer left EX_IDLE without cmd_valid");

endmodule

bind apu_top apu_assert i_assert (
	.clk       (clk),
	.rst       (rst),
	.psel      (psel),
	.penable   (penable),
	.pwrite    (pwrite),
	.paddr     (paddr),
	.pready    (pready),
	.busy      (busy),
	.cmd_valid (cmd_valid)
);

`default_nettype wire

/* src/apu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_top (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     psel,
	input  wire                     penable,
	input  wire                     pwrite,
	input  wire apu_pkg::apb_addr_t paddr,
	input  wire apu_pkg::data_t     pwdata,
	output apu_pkg::data_t          prdata,
	output logic                    pready
);

	logic                busy;
	logic                cmd_valid;
	apu_pkg::apu_cmd_t   cmd;
	logic                host_we;
	apu_pkg::reg_addr_t  host_addr;
	apu_pkg::data_t      host_wdata;
	apu_pkg::reg_addr_t  host_rd_addr;
	apu_pkg::reg_addr_t  exec_rd_addr_b;
	apu_pkg::reg_addr_t  rd_addr_a;
	apu_pkg::reg_addr_t  rd_addr_b;
	apu_pkg::data_t      rd_data_a;
	apu_pkg::data_t      rd_data_b;
	apu_pkg::apu_flags_t flags;
	apu_pkg::data_t      alu_src;
	apu_pkg::data_t      alu_arg;
	logic                alu_c;
	apu_pkg::alu_func_t  alu_func;
	apu_pkg::alu_size_t  alu_sz;
	apu_pkg::data_t      alu_res;
	apu_pkg::apu_flags_t alu_flags;
	logic                wb_we;
	apu_pkg::reg_addr_t  wb_addr;
	apu_pkg::data_t      wb_data;
	apu_pkg::apu_flags_t wb_flags;

	// Sequencer owns port B while a command runs
	assign rd_addr_b = busy ? exec_rd_addr_b : host_rd_addr;

	apu_apb_slave i_slave (
		.clk        (clk),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.busy       (busy),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.rd_addr_b  (host_rd_addr),
		.rd_data_b  (rd_data_b),
		.flags      (flags)
	);

	apu_exec i_exec (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.busy      (busy),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (exec_rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.flags     (flags),
		.alu_src   (alu_src),
		.alu_arg   (alu_arg),
		.alu_c     (alu_c),
		.alu_func  (alu_func),
		.alu_sz    (alu_sz),
		.alu_res   (alu_res),
		.alu_flags (alu_flags),
		.wb_we     (wb_we),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.wb_flags  (wb_flags)
	);

	apu_regfile i_regfile (
		.clk        (clk),
		.rst        (rst),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.wb_we      (wb_we),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.wb_flags   (wb_flags),
		.flags      (flags)
	);

	apu_alu i_alu (
		.src   (alu_src),
		.arg   (alu_arg),
		.c     (alu_c),
		.func  (alu_func),
		.sz    (alu_sz),
		.res   (alu_res),
		.flags (alu_flags)
	);

endmodule

`default_nettype wire

/* src/apu_apb_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_apb_slave (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      psel,
	input  wire                      penable,
	input  wire                      pwrite,
	input  wire apu_pkg::apb_addr_t  paddr,
	input  wire apu_pkg::data_t      pwdata,
	output apu_pkg::data_t           prdata,
	output logic                     pready,
	input  wire                      busy,
	output logic                     cmd_valid,
	output apu_pkg::apu_cmd_t        cmd,
	output logic                     host_we,
	output apu_pkg::reg_addr_t       host_addr,
	output apu_pkg::data_t           host_wdata,
	output apu_pkg::reg_addr_t       rd_addr_b,
	input  wire apu_pkg::data_t      rd_data_b,
	input  wire apu_pkg::apu_flags_t flags
);

	logic           sel_reg;
	logic           sel_cmd;
	logic           sel_status;
	logic           setup;
	logic           done;
	logic           stall;
	apu_pkg::data_t status;
	apu_pkg::data_t rdata;

	// Word decode, byte offset ignored
	assign sel_reg    = paddr[7:5] == apu_pkg::ADDR_REG0[7:5];
	assign sel_cmd    = paddr[7:2] == apu_pkg::ADDR_CMD[7:2];
	assign sel_status = paddr[7:2] == apu_pkg::ADDR_STATUS[7:2];

	assign setup = psel && !penable;
	assign done  = psel && penable && pready;

	// Writes wait for the sequencer, reads never do
	assign stall = pwrite && (busy || cmd_valid);

	always_ff @(posedge clk) begin
		if (rst)
			pready <= 1'b0;
		else if (psel && !done)
			pready <= !stall;
		else
			pready <= 1'b0;
	end

	always_comb begin
		status = '0;
		status[apu_pkg::STATUS_BUSY] = busy;
		status[3:0] = flags;
	end

	// CMD is write only and reads back as 0 like unmapped space
	always_comb begin
		if (sel_reg)
			rdata = rd_data_b;
		else if (sel_status)
			rdata = status;
		else
			rdata = '0;
	end

	// Sampled in setup so data is ready in the first access cycle
	always_ff @(posedge clk) begin
		if (setup && !pwrite)
			prdata <= rdata;
	end

	always_ff @(posedge clk) begin
		if (rst)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= done && pwrite && sel_cmd;
	end

	always_ff @(posedge clk) begin
		if (done && pwrite && sel_cmd)
			cmd <= pwdata[$bits(apu_pkg::apu_cmd_t)-1:0];
	end

	assign host_we    = done && pwrite && sel_reg; // Register written on completing edge
	assign host_addr  = paddr[4:2];
	assign host_wdata = pwdata;
	assign rd_addr_b  = paddr[4:2];

endmodule

`default_nettype wire

/* src/apu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_exec (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      cmd_valid,
	input  wire apu_pkg::apu_cmd_t   cmd,
	output logic                     busy,
	output apu_pkg::reg_addr_t       rd_addr_a,
	output apu_pkg::reg_addr_t       rd_addr_b,
	input  wire apu_pkg::data_t      rd_data_a,
	input  wire apu_pkg::data_t      rd_data_b,
	input  wire apu_pkg::apu_flags_t flags,
	output apu_pkg::data_t           alu_src,
	output apu_pkg::data_t           alu_arg,
	output logic                     alu_c,
	output apu_pkg::alu_func_t       alu_func,
	output apu_pkg::alu_size_t       alu_sz,
	input  wire apu_pkg::data_t      alu_res,
	input  wire apu_pkg::apu_flags_t alu_flags,
	output logic                     wb_we,
	output apu_pkg::reg_addr_t       wb_addr,
	output apu_pkg::data_t           wb_data,
	output apu_pkg::apu_flags_t      wb_flags
);

	apu_pkg::exec_state_t state;
	apu_pkg::apu_cmd_t    cmd_q;
	apu_pkg::data_t       src_q;
	apu_pkg::data_t       arg_q;
	logic                 c_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= apu_pkg::EX_IDLE;
		end else begin
			case (state)
				apu_pkg::EX_IDLE:  if (cmd_valid) state <= apu_pkg::EX_READ;
				apu_pkg::EX_READ:  state <= apu_pkg::EX_WRITE;
				apu_pkg::EX_WRITE: state <= apu_pkg::EX_IDLE;
				default:           state <= apu_pkg::EX_IDLE;
			endcase
		end
	end

	// Command, then operands and stored carry
	always_ff @(posedge clk) begin
		if (state == apu_pkg::EX_IDLE && cmd_valid)
			cmd_q <= cmd;
		if (state == apu_pkg::EX_READ) begin
			src_q <= rd_data_a;
			arg_q <= rd_data_b;
			c_q   <= flags.c;
		end
	end

	assign busy = state != apu_pkg::EX_IDLE;

	// Port B is handed over at top level while busy
	assign rd_addr_a = cmd_q.src;
	assign rd_addr_b = cmd_q.arg;

	assign alu_src  = src_q;
	assign alu_arg  = arg_q;
	assign alu_c    = c_q;
	assign alu_func = cmd_q.func;
	assign alu_sz   = cmd_q.sz;

	// Result lands on the edge that leaves EX_WRITE
	assign wb_we    = state == apu_pkg::EX_WRITE;
	assign wb_addr  = cmd_q.dst;
	assign wb_data  = alu_res;
	assign wb_flags = alu_flags;

endmodule

`default_nettype wire

/* src/apu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_regfile (
	input  wire                      clk,
	input  wire                      rst,
	input  wire apu_pkg::reg_addr_t  rd_addr_a,
	input  wire apu_pkg::reg_addr_t  rd_addr_b,
	output apu_pkg::data_t           rd_data_a,
	output apu_pkg::data_t           rd_data_b,
	input  wire                      host_we,
	input  wire apu_pkg::reg_addr_t  host_addr,
	input  wire apu_pkg::data_t      host_wdata,
	input  wire                      wb_we,
	input  wire apu_pkg::reg_addr_t  wb_addr,
	input  wire apu_pkg::data_t      wb_data,
	input  wire apu_pkg::apu_flags_t wb_flags,
	output apu_pkg::apu_flags_t      flags
);

	apu_pkg::data_t      regs [0:7];
	apu_pkg::apu_flags_t flag_q;
	logic                we;
	apu_pkg::reg_addr_t  waddr;
	apu_pkg::data_t      wdata;

	// Writeback has priority over the host port
	assign we    = wb_we || host_we;
	assign waddr = wb_we ? wb_addr : host_addr;
	assign wdata = wb_we ? wb_data : host_wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Host writes never touch the flags
	always_ff @(posedge clk) begin
		if (rst)
			flag_q <= '0;
		else if (wb_we)
			flag_q <= wb_flags;
	end

	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];
	assign flags     = flag_q;

endmodule

`default_nettype wire

/* src/apu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_alu (
	input  wire apu_pkg::data_t     src,
	input  wire apu_pkg::data_t     arg,
	input  wire                     c,
	input  wire apu_pkg::alu_func_t func,
	input  wire apu_pkg::alu_size_t sz,
	output apu_pkg::data_t          res,
	output apu_pkg::apu_flags_t     flags
);

	logic [5:0]     msb;   // Top bit index at the selected size
	apu_pkg::data_t mask;
	apu_pkg::data_t src_m;
	apu_pkg::data_t arg_m;
	logic           sc;
	logic [32:0]    sum;
	logic [32:0]    dif;
	logic           ca;
	logic           cs;
	logic           cl;
	logic           cr;
	logic           lc;
	logic           rc;
	apu_pkg::data_t r_rr;
	apu_pkg::data_t r_rl;
	logic [15:0]    mul_lo;
	logic [31:0]    mul_hi;
	apu_pkg::data_t r_mul;
	logic           fc;

	assign msb = {1'b0, sz, 3'b111};

	always_comb begin
		case (sz)
			2'd0:    mask = 32'h0000_00ff;
			2'd1:    mask = 32'h0000_ffff;
			2'd2:    mask = 32'h00ff_ffff;
			default: mask = 32'hffff_ffff;
		endcase
	end

	assign src_m = src & mask;
	assign arg_m = arg & mask;

	// Carry in only for ADC and SBC
	assign sc = c && func[0];

	// Bit above the sized field is the carry or the borrow
	assign sum = {1'b0, src_m} + {1'b0, arg_m} + {32'd0, sc};
	assign dif = {1'b0, src_m} - {1'b0, arg_m} - {32'd0, sc};
	assign ca  = sum[msb + 6'd1];
	assign cs  = dif[msb + 6'd1];

	// Bits leaving the field on a shift
	assign cl = src[msb[4:0]];
	assign cr = src[0];

	assign lc = func[0] ? c : cl;            // RLC takes carry, RL rotates
	assign rc = func[1] ? (func[0] ? 1'b0 : cl) : // SRZ, SRA
	                      (func[0] ? c : cr);      // RRC, RR

	always_comb begin
		r_rr = src_m >> 1;
		r_rr[msb[4:0]] = rc;
	end

	assign r_rl = ((src << 1) | {31'd0, lc}) & mask;

	// 8x8 for the two narrow sizes, 16x16 above
	assign mul_lo = src[7:0] * arg[7:0];
	assign mul_hi = src[15:0] * arg[15:0];
	assign r_mul  = (sz[1] ? mul_hi : {16'd0, mul_lo}) & mask;

	always_comb begin
		unique case (func)
			apu_pkg::FN_LOAD: begin
				res = src;
				fc  = 1'b0;
			end
			apu_pkg::FN_AND: begin
				res = src & arg;
				fc  = 1'b0;
			end
			apu_pkg::FN_OR: begin
				res = src | arg;
				fc  = 1'b0;
			end
			apu_pkg::FN_XOR: begin
				res = src ^ arg;
				fc  = 1'b0;
			end
			apu_pkg::FN_ADD, apu_pkg::FN_ADC: begin
				res = sum[31:0] & mask;
				fc  = ca;
			end
			apu_pkg::FN_SUB, apu_pkg::FN_SBC: begin
				res = dif[31:0] & mask;
				fc  = cs;
			end
			apu_pkg::FN_RR, apu_pkg::FN_RRC, apu_pkg::FN_SRA, apu_pkg::FN_SRZ: begin
				res = r_rr;
				fc  = cr;
			end
			apu_pkg::FN_RL, apu_pkg::FN_RLC: begin
				res = r_rl;
				fc  = cl;
			end
			apu_pkg::FN_MUL, apu_pkg::FN_MULS: begin
				res = r_mul;
				fc  = 1'b0;
			end
		endcase
	end

	// Z and S look at the sized field even for full width logic results
	always_comb begin
		flags.z = (res & mask) == '0;
		flags.s = res[msb[4:0]];
		flags.c = fc;
		flags.v = 1'b0;     // No overflow detection
	end

endmodule

`default_nettype wire

/* src/apu_pkg.sv */
`default_nettype none

package apu_pkg;

	typedef logic [31:0] data_t;     // Register, operand and APB data word
	typedef logic [2:0]  reg_addr_t;
	typedef logic [3:0]  alu_func_t;
	typedef logic [1:0]  alu_size_t; // 0 is 8 bits, 1 is 16, 2 is 24, 3 is 32
	typedef logic [7:0]  apb_addr_t;

	// ALU function codes
	// Paired functions differ in bit 0 only, the ALU uses that bit as carry select
	localparam alu_func_t FN_LOAD = 4'd0;
	localparam alu_func_t FN_AND  = 4'd1;
	localparam alu_func_t FN_OR   = 4'd2;
	localparam alu_func_t FN_XOR  = 4'd3;
	localparam alu_func_t FN_ADD  = 4'd4;
	localparam alu_func_t FN_ADC  = 4'd5;
	localparam alu_func_t FN_SUB  = 4'd6;
	localparam alu_func_t FN_SBC  = 4'd7;
	localparam alu_func_t FN_RR   = 4'd8;
	localparam alu_func_t FN_RRC  = 4'd9;
	localparam alu_func_t FN_SRA  = 4'd10;
	localparam alu_func_t FN_SRZ  = 4'd11;
	localparam alu_func_t FN_RL   = 4'd12;
	localparam alu_func_t FN_RLC  = 4'd13;
	localparam alu_func_t FN_MUL  = 4'd14;
	localparam alu_func_t FN_MULS = 4'd15;

	typedef struct packed {
		logic z;
		logic s;
		logic c;
		logic v;
	} apu_flags_t;

	// Low 15 bits of the CMD write data
	typedef struct packed {
		alu_func_t func;
		alu_size_t sz;
		reg_addr_t dst;
		reg_addr_t src;
		reg_addr_t arg;
	} apu_cmd_t;

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_READ,
		EX_WRITE
	} exec_state_t;

	// APB register map
	localparam apb_addr_t ADDR_REG0   = 8'h00; // Register n at 0x00 + 4n
	localparam apb_addr_t ADDR_CMD    = 8'h20;
	localparam apb_addr_t ADDR_STATUS = 8'h24;
	localparam int        STATUS_BUSY = 4;     // Busy bit, flags sit below it

endpackage

`default_nettype wire
